// File: source/fixedDivPkg.sv
`default_nettype none

// Shared arithmetic definitions for the fixed-point divider
package fixedDivPkg;

	// -------------------------------------------------------------------------
	// Iterative core FSM encoding
	// -------------------------------------------------------------------------

	// Idle waits for coreStart
	// Load decides between the iterations and the zero-divisor exit
	// Iterate settles one quotient bit per clock
	// Finish marks the single done cycle
	typedef enum logic [1:0] {
		stIdle    = 2'd0,
		stLoad    = 2'd1,
		stIterate = 2'd2,
		stFinish  = 2'd3
	} divStateT;

	// -------------------------------------------------------------------------
	// Result flags, one bit each
	// -------------------------------------------------------------------------

	// divByZero wins over overflow, never both set
	typedef struct packed {
		logic divByZero;
		logic overflow;
	} divFlagsT;

endpackage

`default_nettype wire

// File: source/divRegMapPkg.sv
`default_nettype none

// APB register map of the divider peripheral
package divRegMapPkg;

	// -------------------------------------------------------------------------
	// Byte offsets on the 5-bit APB address
	// -------------------------------------------------------------------------

	localparam logic [4:0] regDividend = 5'h00;
	localparam logic [4:0] regDivisor  = 5'h04;
	localparam logic [4:0] regControl  = 5'h08;
	localparam logic [4:0] regStatus   = 5'h0C;
	localparam logic [4:0] regQuotient = 5'h10;

	// -------------------------------------------------------------------------
	// Bit positions
	// -------------------------------------------------------------------------

	// Control register, start is self clearing
	localparam int ctrlStartBit = 0;

	// Status register
	localparam int statBusyBit     = 0;
	localparam int statDoneBit     = 1;
	localparam int statDivZeroBit  = 2;
	localparam int statOverflowBit = 3;

endpackage

`default_nettype wire

// File: source/unsignedFixedDivider.sv
`timescale 1ns/1ps
`default_nettype none

// Restoring long division of (magDividend << FRAC) by magDivisor
// One quotient bit per clock, MSB first
module unsignedFixedDivider #(
	parameter int WIDTH = 32,
	parameter int FRAC  = 16
) (
	input  logic             Clock,
	input  logic             rstN,
	input  logic             coreStart,
	input  logic [WIDTH-1:0] magDividend,
	input  logic [WIDTH-1:0] magDivisor,
	output logic [WIDTH:0]   magQuotient,
	output logic             zeroDivisor,
	output logic             coreDone
);

	import fixedDivPkg::*;

	// Scaled dividend has WIDTH+FRAC bits, so that many quotient bits
	localparam int stepCount = WIDTH + FRAC;
	localparam int cntWidth  = $clog2(stepCount);
	localparam int qWidth    = WIDTH + 1;

	divStateT state;

	logic [stepCount-1:0] dividendSr;
	logic [stepCount-1:0] quotSr;
	logic [WIDTH-1:0]     divisorReg;
	logic [WIDTH-1:0]     remReg;
	logic [cntWidth-1:0]  iterCount;
	logic                 zeroDiv;

	logic [WIDTH:0]       remShift;
	logic [WIDTH+1:0]     trialDiff;
	logic                 quotBit;
	logic                 stepEn;
	logic                 lastStep;

	// -------------------------------------------------------------------------
	// One division step
	// -------------------------------------------------------------------------

	// Bring down the next dividend bit
	// Remainder stays below the divisor, so one extra bit is enough
	always_comb
	begin
		remShift  = {remReg, dividendSr[stepCount-1]};
		trialDiff = {1'b0, remShift} - {2'b00, divisorReg};
		// Non-negative difference means the divisor fits
		quotBit   = ~trialDiff[WIDTH+1];
	end

	// The load cycle already performs the first step
	assign stepEn   = ((state == stLoad) && !zeroDiv) || (state == stIterate);
	assign lastStep = (iterCount == '0);

	// -------------------------------------------------------------------------
	// Datapath
	// -------------------------------------------------------------------------

	always_ff @(posedge Clock)
	begin
		if ((state == stIdle) && coreStart)
		begin
			// Scale the dividend by 2^FRAC
			dividendSr <= stepCount'(magDividend) << FRAC;
			divisorReg <= magDivisor;
			remReg     <= '0;
			quotSr     <= '0;
			iterCount  <= cntWidth'(stepCount - 1);
			zeroDiv    <= (magDivisor == '0);
		end
		else if (stepEn)
		begin
			dividendSr <= dividendSr << 1;
			// Restore when the trial subtraction went negative
			remReg     <= quotBit ? trialDiff[WIDTH-1:0] : remShift[WIDTH-1:0];
			quotSr     <= (quotSr << 1) | stepCount'(quotBit);
			iterCount  <= iterCount - 1'b1;
		end
	end

	// -------------------------------------------------------------------------
	// Control FSM
	// -------------------------------------------------------------------------

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state <= stIdle;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (coreStart)
						state <= stLoad;
				end
				stLoad:
				begin
					// Zero divisor skips every iteration
					state <= zeroDiv ? stFinish : stIterate;
				end
				stIterate:
				begin
					if (lastStep)
						state <= stFinish;
				end
				default:
				begin
					state <= stIdle;
				end
			endcase
		end
	end

	assign coreDone    = (state == stFinish);
	assign zeroDivisor = zeroDiv;

	// Anything above bit WIDTH is overflow anyway, so clamp it into WIDTH+1 bits
	assign magQuotient = (|(quotSr >> qWidth)) ? {qWidth{1'b1}} : qWidth'(quotSr);

	// -------------------------------------------------------------------------
	// Checks
	// -------------------------------------------------------------------------

	// Upstream must wait for the previous division
	startOnlyWhenIdle: assert property (@(posedge Clock) disable iff (!rstN)
		coreStart |-> (state == stIdle));

	// Done is a single-cycle pulse
	doneIsPulse: assert property (@(posedge Clock) disable iff (!rstN)
		coreDone |=> !coreDone);

endmodule

`default_nettype wire

// File: source/signedFixedDivider.sv
`timescale 1ns/1ps
`default_nettype none

// Signed Q-format divide around the unsigned core
// Adds one input and one output register stage
module signedFixedDivider #(
	parameter int WIDTH = 32,
	parameter int FRAC  = 16
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 start,
	input  logic [WIDTH-1:0]     dividend,
	input  logic [WIDTH-1:0]     divisor,
	output logic [WIDTH-1:0]     quotient,
	output fixedDivPkg::divFlagsT flags,
	output logic                 done
);

	// Largest positive Q value
	localparam logic [WIDTH-1:0] maxPos = {1'b0, {(WIDTH-1){1'b1}}};

	logic [WIDTH-1:0] dividendReg;
	logic [WIDTH-1:0] divisorReg;
	logic             resultNeg;
	logic             coreStart;
	logic [WIDTH-1:0] magDividend;
	logic [WIDTH-1:0] magDivisor;
	logic [WIDTH:0]   magQuotient;
	logic             zeroDivisor;
	logic             coreDone;
	logic             overflowNow;
	logic [WIDTH-1:0] satMag;
	logic [WIDTH-1:0] resultWord;

	// Operand capture and sign of the true result
	always_ff @(posedge Clock)
	begin
		if (start)
		begin
			dividendReg <= dividend;
			divisorReg  <= divisor;
			resultNeg   <= dividend[WIDTH-1] ^ divisor[WIDTH-1];
		end
	end

	// Two's-complement magnitudes, most negative value still fits unsigned
	assign magDividend = dividendReg[WIDTH-1] ? -dividendReg : dividendReg;
	assign magDivisor  = divisorReg[WIDTH-1] ? -divisorReg : divisorReg;

	unsignedFixedDivider #(
		.WIDTH(WIDTH),
		.FRAC (FRAC)
	) core_i (
		.Clock      (Clock),
		.rstN       (rstN),
		.coreStart  (coreStart),
		.magDividend(magDividend),
		.magDivisor (magDivisor),
		.magQuotient(magQuotient),
		.zeroDivisor(zeroDivisor),
		.coreDone   (coreDone)
	);

	// -------------------------------------------------------------------------
	// Sign restore and saturation
	// -------------------------------------------------------------------------

	always_comb
	begin
		overflowNow = (magQuotient > {1'b0, maxPos});
		if (zeroDivisor || overflowNow)
			satMag = maxPos;
		else
			satMag = magQuotient[WIDTH-1:0];
		// Divide by zero is always positive full scale
		resultWord = (resultNeg && !zeroDivisor) ? -satMag : satMag;
	end

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			coreStart <= 1'b0;
			done      <= 1'b0;
			flags     <= '0;
		end
		else
		begin
			coreStart <= start;
			done      <= coreDone;
			if (coreDone)
			begin
				flags.divByZero <= zeroDivisor;
				flags.overflow  <= !zeroDivisor && overflowNow;
			end
		end
	end

	// Result word held until the next division finishes
	always_ff @(posedge Clock)
	begin
		if (coreDone)
			quotient <= resultWord;
	end

	// done only at one of the two fixed latencies after start
	doneNeedsStart: assert property (@(posedge Clock) disable iff (!rstN)
		done |-> ($past(start, WIDTH + FRAC + 3) || $past(start, 4)));

endmodule

`default_nettype wire

// File: source/divApbRegs.sv
`timescale 1ns/1ps
`default_nettype none

// APB3 slave for the divider
// Operands, start control, status and the stalling quotient read
module divApbRegs #(
	parameter int WIDTH = 32
) (
	input  logic                  Clock,
	input  logic                  rstN,
	input  logic                  pSel,
	input  logic                  pEnable,
	input  logic                  pWrite,
	input  logic [4:0]            pAddr,
	input  logic [WIDTH-1:0]      pWData,
	output logic [WIDTH-1:0]      pRData,
	output logic                  pReady,
	output logic                  pSlvErr,
	output logic [WIDTH-1:0]      dividend,
	output logic [WIDTH-1:0]      divisor,
	output logic                  start,
	input  logic [WIDTH-1:0]      quotient,
	input  fixedDivPkg::divFlagsT flags,
	input  logic                  done
);

	import fixedDivPkg::*;
	import divRegMapPkg::*;

	logic             busy;
	logic             doneStat;
	divFlagsT         flagStat;

	logic             addrMapped;
	logic             writableReg;
	logic             readOnlyReg;
	logic             accessErr;
	logic             quotStall;
	logic             complete;
	logic             writeOk;
	logic             readOk;
	logic             startReq;
	logic [WIDTH-1:0] statusWord;
	logic [WIDTH-1:0] readMux;

	// -------------------------------------------------------------------------
	// Address decode
	// -------------------------------------------------------------------------

	always_comb
	begin
		addrMapped  = pAddr inside {regDividend, regDivisor, regControl, regStatus,
			regQuotient};
		writableReg = pAddr inside {regDividend, regDivisor, regControl};
		readOnlyReg = pAddr inside {regStatus, regQuotient};
		// Unmapped, read-only target, or operand/control change while busy
		accessErr   = !addrMapped || (pWrite && readOnlyReg) || (pWrite && writableReg && busy);
		quotStall   = !pWrite && (pAddr == regQuotient) && busy;
	end

	// Wait states only for a quotient read during a division
	assign pReady   = !(pSel && pEnable && quotStall);
	assign complete = pSel && pEnable && pReady;
	assign pSlvErr  = complete && accessErr;
	assign writeOk  = complete && pWrite && !accessErr;
	assign readOk   = complete && !pWrite && !accessErr;
	assign startReq = writeOk && (pAddr == regControl) && pWData[ctrlStartBit];

	// -------------------------------------------------------------------------
	// Read path
	// -------------------------------------------------------------------------

	always_comb
	begin
		statusWord                  = '0;
		statusWord[statBusyBit]     = busy;
		statusWord[statDoneBit]     = doneStat;
		statusWord[statDivZeroBit]  = flagStat.divByZero;
		statusWord[statOverflowBit] = flagStat.overflow;

		case (pAddr)
			regDividend: readMux = dividend;
			regDivisor:  readMux = divisor;
			regStatus:   readMux = statusWord;
			regQuotient: readMux = quotient;
			// Control reads back as zero
			default:     readMux = '0;
		endcase
	end

	assign pRData = readOk ? readMux : '0;

	// -------------------------------------------------------------------------
	// Operand registers
	// -------------------------------------------------------------------------

	always_ff @(posedge Clock)
	begin
		if (writeOk && (pAddr == regDividend))
			dividend <= pWData;
		if (writeOk && (pAddr == regDivisor))
			divisor <= pWData;
	end

	// -------------------------------------------------------------------------
	// Start pulse and status
	// -------------------------------------------------------------------------

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			start    <= 1'b0;
			busy     <= 1'b0;
			doneStat <= 1'b0;
			flagStat <= '0;
		end
		else
		begin
			// One-cycle pulse after the completing control write
			start <= startReq;

			if (startReq)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;

			// Done sticks until software fetches the quotient
			if (done)
			begin
				doneStat <= 1'b1;
				flagStat <= flags;
			end
			else if (readOk && (pAddr == regQuotient))
			begin
				doneStat <= 1'b0;
			end
		end
	end

	// -------------------------------------------------------------------------
	// Bus protocol checks
	// -------------------------------------------------------------------------

	enableNeedsSel: assert property (@(posedge Clock) disable iff (!rstN)
		pEnable |-> pSel);

	// Master holds the transfer while we insert wait states
	addrStableInWait: assert property (@(posedge Clock) disable iff (!rstN)
		(pSel && pEnable && !pReady) |=> (pSel && $stable(pAddr)));

endmodule

`default_nettype wire

// File: source/fixedDividerTop.sv
`timescale 1ns/1ps
`default_nettype none

// Divider peripheral top, APB register block feeding the signed divider
module fixedDividerTop #(
	parameter int WIDTH = 32,
	parameter int FRAC  = 16
) (
	input  logic             Clock,
	input  logic             rstN,
	input  logic             pSel,
	input  logic             pEnable,
	input  logic             pWrite,
	input  logic [4:0]       pAddr,
	input  logic [WIDTH-1:0] pWData,
	output logic [WIDTH-1:0] pRData,
	output logic             pReady,
	output logic             pSlvErr
);

	import fixedDivPkg::*;

	logic [WIDTH-1:0] dividend;
	logic [WIDTH-1:0] divisor;
	logic [WIDTH-1:0] quotient;
	logic             start;
	logic             done;
	divFlagsT         flags;

	// Bus side
	divApbRegs #(
		.WIDTH(WIDTH)
	) regs_i (
		.Clock   (Clock),
		.rstN    (rstN),
		.pSel    (pSel),
		.pEnable (pEnable),
		.pWrite  (pWrite),
		.pAddr   (pAddr),
		.pWData  (pWData),
		.pRData  (pRData),
		.pReady  (pReady),
		.pSlvErr (pSlvErr),
		.dividend(dividend),
		.divisor (divisor),
		.start   (start),
		.quotient(quotient),
		.flags   (flags),
		.done    (done)
	);

	// Arithmetic side
	signedFixedDivider #(
		.WIDTH(WIDTH),
		.FRAC (FRAC)
	) div_i (
		.Clock   (Clock),
		.rstN    (rstN),
		.start   (start),
		.dividend(dividend),
		.divisor (divisor),
		.quotient(quotient),
		.flags   (flags),
		.done    (done)
	);

endmodule

`default_nettype wire

// File: verif/tbClockGen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and a synchronous active-low reset
module tbClockGen #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 10
) (
	output logic Clock,
	output logic rstN
);

	initial
	begin
		Clock = 1'b0;
		forever
			#(periodNs / 2) Clock = ~Clock;
	end

	// Release shortly after an edge so the DUT sees a clean deassert
	initial
	begin
		rstN = 1'b0;
		repeat (resetCycles)
			@(posedge Clock);
		#(periodNs / 10);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/divModel.svh
`ifndef divModelSvh
`define divModelSvh

// Reference quotient and flags for the Q-format divide
// Expects dataW and fracBits from the including module
function automatic logic [dataW-1:0] modelQuotient(
	input  logic [dataW-1:0] dividendIn,
	input  logic [dataW-1:0] divisorIn,
	output logic             divZero,
	output logic             ovf
);
	longint sa;
	longint sb;
	longint q;
	longint maxPos;

	maxPos  = (longint'(1) <<< (dataW - 1)) - 1;
	sa      = longint'($signed(dividendIn));
	sb      = longint'($signed(divisorIn));
	divZero = (sb == 0);
	ovf     = 1'b0;
	// Zero divisor gives positive full scale whatever the dividend sign
	if (divZero)
		return dataW'(maxPos);
	// SV division truncates toward zero
	q = (sa * (longint'(1) <<< fracBits)) / sb;
	if (q > maxPos)
	begin
		ovf = 1'b1;
		q   = maxPos;
	end
	else if (q < -maxPos)
	begin
		// Saturated magnitude keeps the sign of the true result
		ovf = 1'b1;
		q   = -maxPos;
	end
	return dataW'(q);
endfunction

`endif

// File: verif/tbFixedDivider.sv
`timescale 1ns/1ps
`default_nettype none

module tbFixedDivider;

	localparam int dataW        = 32;
	localparam int fracBits     = 16;
	localparam int driveDelay   = 10;
	localparam int readyTimeout = 200;
	localparam int doneTimeout  = 200;
	localparam int resetTimeout = 50;

	// Register map, kept apart from the RTL package
	localparam logic [4:0] regDividend = 5'h00;
	localparam logic [4:0] regDivisor  = 5'h04;
	localparam logic [4:0] regControl  = 5'h08;
	localparam logic [4:0] regStatus   = 5'h0C;
	localparam logic [4:0] regQuotient = 5'h10;
	localparam int busyBit    = 0;
	localparam int doneBit    = 1;
	localparam int divZeroBit = 2;
	localparam int ovfBit     = 3;

	logic             Clock;
	logic             rstN;
	logic             pSel;
	logic             pEnable;
	logic             pWrite;
	logic [4:0]       pAddr;
	logic [dataW-1:0] pWData;
	logic [dataW-1:0] pRData;
	logic             pReady;
	logic             pSlvErr;
	int               overflowSeen;
	int unsigned      seedDummy;

	`include "divModel.svh"

	tbClockGen #(
		.periodNs   (100),
		.resetCycles(10)
	) clk_i (
		.Clock(Clock),
		.rstN (rstN)
	);

	fixedDividerTop #(
		.WIDTH(dataW),
		.FRAC (fracBits)
	) dut_i (
		.Clock  (Clock),
		.rstN   (rstN),
		.pSel   (pSel),
		.pEnable(pEnable),
		.pWrite (pWrite),
		.pAddr  (pAddr),
		.pWData (pWData),
		.pRData (pRData),
		.pReady (pReady),
		.pSlvErr(pSlvErr)
	);

	// -------------------------------------------------------------------------
	// Failure reporting
	// -------------------------------------------------------------------------

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	task automatic checkValue(input string name, input logic [dataW-1:0] observed,
		input logic [dataW-1:0] expected);
		if (observed !== expected)
		begin
			$display("[ERROR] %0t %s observed 0x%08h expected 0x%08h", $time, name,
				observed, expected);
			abortRun("Stopping at the first mismatch");
		end
	endtask

	// -------------------------------------------------------------------------
	// APB master
	// -------------------------------------------------------------------------

	// Drive after the rising edge, sample at the falling edge
	task automatic busTransfer(input logic write, input logic [4:0] addr,
		input logic [dataW-1:0] wdata, output logic [dataW-1:0] rdata, output logic err,
		output int waits);
		int polls;
		@(posedge Clock);
		#driveDelay;
		pSel    = 1'b1;
		pEnable = 1'b0;
		pWrite  = write;
		pAddr   = addr;
		pWData  = wdata;
		@(posedge Clock);
		#driveDelay;
		pEnable = 1'b1;
		@(negedge Clock);
		polls = 0;
		while (!pReady)
		begin
			polls++;
			if (polls > readyTimeout)
				abortRun("Timeout waiting for pReady on an APB transfer");
			@(negedge Clock);
		end
		waits = polls;
		rdata = pRData;
		err   = pSlvErr;
		// Transfer completes on this edge
		@(posedge Clock);
		#driveDelay;
		pSel    = 1'b0;
		pEnable = 1'b0;
		pWrite  = 1'b0;
	endtask

	task automatic apbWrite(input logic [4:0] addr, input logic [dataW-1:0] data,
		output logic err);
		logic [dataW-1:0] unused;
		int               waits;
		busTransfer(1'b1, addr, data, unused, err, waits);
	endtask

	task automatic apbRead(input logic [4:0] addr, output logic [dataW-1:0] data,
		output logic err, output int waits);
		busTransfer(1'b0, addr, '0, data, err, waits);
	endtask

	// -------------------------------------------------------------------------
	// Division sequences
	// -------------------------------------------------------------------------

	function automatic logic [dataW-1:0] randomOperand(input int unsigned magFloor,
		input int unsigned magCeil);
		logic [dataW-1:0] mag;
		mag = magFloor + ($urandom % (magCeil - magFloor));
		if ($urandom % 2)
			return -mag;
		return mag;
	endfunction

	task automatic startDivision(input logic [dataW-1:0] a, input logic [dataW-1:0] b);
		logic err;
		apbWrite(regDividend, a, err);
		checkValue("pSlvErr dividend write", err, 0);
		apbWrite(regDivisor, b, err);
		checkValue("pSlvErr divisor write", err, 0);
		apbWrite(regControl, 1, err);
		checkValue("pSlvErr control write", err, 0);
	endtask

	// Poll status until done, bounded by a poll count
	task automatic waitForDone(output logic [dataW-1:0] status);
		logic err;
		int   waits;
		int   polls;
		polls = 0;
		apbRead(regStatus, status, err, waits);
		while (!status[doneBit])
		begin
			polls++;
			if (polls > doneTimeout)
				abortRun("Timeout waiting for the done status bit");
			apbRead(regStatus, status, err, waits);
		end
	endtask

	task automatic checkOutcome(input logic [dataW-1:0] a, input logic [dataW-1:0] b,
		input logic [dataW-1:0] status, input logic [dataW-1:0] q);
		logic             expZero;
		logic             expOvf;
		logic [dataW-1:0] expQ;
		expQ = modelQuotient(a, b, expZero, expOvf);
		checkValue("quotient", q, expQ);
		checkValue("status.divByZero", status[divZeroBit], expZero);
		checkValue("status.overflow", status[ovfBit], expOvf);
		if (expOvf)
			overflowSeen++;
	endtask

	task automatic runDivision(input logic [dataW-1:0] a, input logic [dataW-1:0] b,
		output logic [dataW-1:0] q);
		logic [dataW-1:0] status;
		logic             err;
		int               waits;
		startDivision(a, b);
		waitForDone(status);
		checkValue("status.busy", status[busyBit], 0);
		apbRead(regQuotient, q, err, waits);
		checkValue("pSlvErr quotient read", err, 0);
		checkOutcome(a, b, status, q);
		// Fetching the quotient clears done
		apbRead(regStatus, status, err, waits);
		checkValue("status.done after quotient read", status[doneBit], 0);
	endtask

	// Quotient read straight after start, optionally with refused writes first
	task automatic divideWithStall(input logic [dataW-1:0] a, input logic [dataW-1:0] b,
		input logic pokeWhileBusy);
		logic [dataW-1:0] q;
		logic [dataW-1:0] status;
		logic             err;
		int               waits;
		startDivision(a, b);
		if (pokeWhileBusy)
		begin
			apbWrite(regControl, 1, err);
			checkValue("pSlvErr start while busy", err, 1);
			apbWrite(regDividend, ~a, err);
			checkValue("pSlvErr dividend write while busy", err, 1);
		end
		apbRead(regQuotient, q, err, waits);
		checkValue("pSlvErr stalled quotient read", err, 0);
		if (waits == 0)
			abortRun("Quotient read during a division got no wait states");
		apbRead(regStatus, status, err, waits);
		checkOutcome(a, b, status, q);
		checkValue("status.done after quotient read", status[doneBit], 0);
		apbRead(regDividend, q, err, waits);
		checkValue("dividend register", q, a);
	endtask

	// -------------------------------------------------------------------------
	// Main sequence
	// -------------------------------------------------------------------------

	initial
	begin
		logic [dataW-1:0] a;
		logic [dataW-1:0] b;
		logic [dataW-1:0] q;
		logic             err;
		int               waits;
		int               polls;

		seedDummy    = $urandom(32'hd0e1891d);
		overflowSeen = 0;
		pSel         = 1'b0;
		pEnable      = 1'b0;
		pWrite       = 1'b0;
		pAddr        = '0;
		pWData       = '0;

		polls = 0;
		while (!rstN)
		begin
			polls++;
			if (polls > resetTimeout)
				abortRun("Reset was never released");
			@(posedge Clock);
		end
		@(negedge Clock);
		checkValue("pRData after reset", pRData, 0);
		checkValue("pSlvErr after reset", pSlvErr, 0);

		// Small operands, no flags expected
		for (int i = 0; i < 200; i++)
		begin
			a = randomOperand(0, 1 << 20);
			b = randomOperand(64, 1 << 20);
			runDivision(a, b, q);
		end

		// Saturation both ways, plus one exact mixed-sign case
		runDivision(32'h7FFFFFFF, 32'h00000001, q);
		checkValue("positive saturation", q, 32'h7FFFFFFF);
		runDivision(32'h80000000, 32'h00010000, q);
		checkValue("negative saturation", q, 32'h80000001);
		runDivision(32'hFFFF8000, 32'h00020000, q);
		checkValue("mixed-sign quotient", q, 32'hFFFFC000);
		for (int i = 0; i < 40; i++)
		begin
			a = $urandom;
			b = randomOperand(1, 1 << 12);
			runDivision(a, b, q);
		end
		for (int i = 0; i < 20; i++)
		begin
			a = $urandom;
			b = $urandom;
			runDivision(a, b, q);
		end
		if (overflowSeen == 0)
			abortRun("No division produced an overflow");

		// Zero divisor
		for (int i = 0; i < 5; i++)
		begin
			a = $urandom;
			runDivision(a, 0, q);
			checkValue("quotient on zero divisor", q, 32'h7FFFFFFF);
		end

		// Stalled reads and refused accesses while busy
		divideWithStall(randomOperand(0, 1 << 20), randomOperand(64, 1 << 20), 1'b0);
		divideWithStall(randomOperand(0, 1 << 20), randomOperand(64, 1 << 20), 1'b1);

		// Access rules
		apbRead(5'h14, q, err, waits);
		checkValue("pSlvErr unmapped read", err, 1);
		apbWrite(5'h1C, 32'h1, err);
		checkValue("pSlvErr unmapped write", err, 1);
		apbWrite(regStatus, 32'hF, err);
		checkValue("pSlvErr status write", err, 1);
		apbWrite(regQuotient, 32'h1, err);
		checkValue("pSlvErr quotient write", err, 1);
		apbRead(regControl, q, err, waits);
		checkValue("pSlvErr control read", err, 0);
		checkValue("control readback", q, 0);
		runDivision(randomOperand(0, 1 << 20), randomOperand(64, 1 << 20), q);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verif
source/fixedDivPkg.sv
source/divRegMapPkg.sv
source/unsignedFixedDivider.sv
source/signedFixedDivider.sv
source/divApbRegs.sv
source/fixedDividerTop.sv
verif/tbClockGen.sv
verif/tbFixedDivider.sv
